// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       := tb_mips_core
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FLIST)) sim/tb_program.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --assert --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+sim
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/mips_core.sv
sim/tb_mips_core.sv

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            clk,
    input  logic                            arst_n,
    input  mips_pkg::inst_u                 if_inst,
    input  logic [mips_pkg::XLEN-1:0]       if_pc_plus4,
    input  logic                            if_valid,
    input  logic                            wb_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_dest,
    input  logic [mips_pkg::XLEN-1:0]       wb_data,
    input  logic                            redirect,
    input  mips_pkg::ex_mem_t               ex_mem,
    output mips_pkg::id_ex_t                id_ex,
    output logic                            stall,
    output logic                            halt_seen
);
    import mips_pkg::*;

    ctrl_t                 ctrl;
    logic                  uses_rs;
    logic                  uses_rt;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       imm_ext;
    logic [XLEN-1:0]       jump_target;
    logic                  dec_valid;
    logic                  hazard_ex;
    logic                  hazard_mem;
    logic                  issue;

    assign rs          = if_inst.r.rs;
    assign rt          = if_inst.r.rt;
    assign imm_ext     = {{(XLEN-16){if_inst.i.imm[15]}}, if_inst.i.imm};
    assign jump_target = {if_pc_plus4[XLEN-1:XLEN-4], if_inst.j.target, 2'b00};

    register_file u_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_en   (wb_en),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        dest        = if_inst.i.rt;
        case (if_inst.r.op)
            OP_SPECIAL: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                dest           = if_inst.r.rd;
                ctrl.reg_write = 1'b1;
                case (if_inst.r.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SYSCALL: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.halt      = 1'b1;
                        uses_rs        = 1'b0;
                        uses_rt        = 1'b0;
                    end
                    // unknown functions retire as nops
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                uses_rs          = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = (if_inst.i.op == OP_LW);
            end
            OP_SW: begin
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ: begin
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
                ctrl.branch = 1'b1;
            end
            OP_J:    ctrl.jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // nothing decodes once the halt has gone down the pipe
    assign dec_valid  = if_valid && !halt_seen;
    assign hazard_ex  = id_ex.valid && id_ex.ctrl.reg_write && (id_ex.dest != '0)
                     && ((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));
    assign hazard_mem = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dest != '0)
                     && ((uses_rs && ex_mem.dest == rs) || (uses_rt && ex_mem.dest == rt));
    assign stall      = dec_valid && (hazard_ex || hazard_mem);
    assign issue      = dec_valid && !stall && !redirect;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex     <= '0;
            halt_seen <= 1'b0;
        end else begin
            id_ex.valid       <= issue;
            id_ex.pc_plus4    <= if_pc_plus4;
            id_ex.ctrl        <= ctrl;
            id_ex.rs_data     <= rs_data;
            id_ex.rt_data     <= rt_data;
            id_ex.imm_ext     <= imm_ext;
            id_ex.jump_target <= jump_target;
            id_ex.dest        <= dest;
            if (issue && ctrl.halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mips_pkg::id_ex_t          id_ex,
    output logic                      redirect,
    output logic [mips_pkg::XLEN-1:0] redirect_pc,
    output mips_pkg::ex_mem_t         ex_mem
);
    import mips_pkg::*;

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] branch_target;
    logic            take_branch;

    assign operand_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : id_ex.rt_data;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = id_ex.rs_data - operand_b;
            ALU_AND: alu_result = id_ex.rs_data & operand_b;
            ALU_OR:  alu_result = id_ex.rs_data | operand_b;
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}},
                              $signed(id_ex.rs_data) < $signed(operand_b)};
            end
            default: alu_result = id_ex.rs_data + operand_b;
        endcase
    end

    // the offset counts words from the instruction after the beq
    assign branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[XLEN-3:0], 2'b00};
    assign take_branch   = id_ex.ctrl.branch && (id_ex.rs_data == id_ex.rt_data);
    assign redirect      = id_ex.valid && (take_branch || id_ex.ctrl.jump);
    assign redirect_pc   = id_ex.ctrl.jump ? id_ex.jump_target : branch_target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.rt_data;
            ex_mem.dest       <= id_ex.dest;
        end
    end

    // the instruction behind a taken branch or jump never reaches execute
    a_redirect_flush: assert property (
        @(posedge clk) disable iff (!arst_n) redirect |=> !id_ex.valid
    );

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      stall,
    input  logic                      halt_seen,
    input  logic                      redirect,
    input  logic [mips_pkg::XLEN-1:0] redirect_pc,
    input  logic [mips_pkg::XLEN-1:0] inst,
    output logic [mips_pkg::XLEN-1:0] inst_addr,
    output mips_pkg::inst_u           if_inst,
    output logic [mips_pkg::XLEN-1:0] if_pc_plus4,
    output logic                      if_valid
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4  = pc + XLEN'(4);
    assign inst_addr = pc;

    // a redirect wins over both stall and halt and drops the word in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            if_valid <= 1'b0;
        end else if (halt_seen) begin
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc_plus4;
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_inst     <= inst;
            if_pc_plus4 <= pc_plus4;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) inst_addr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== hdl/memory_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                            clk,
    input  logic                            arst_n,
    input  mips_pkg::ex_mem_t               ex_mem,
    output logic [mips_pkg::XLEN-1:0]       mem_addr,
    output logic [mips_pkg::XLEN-1:0]       mem_data_in,
    output logic                            mem_write_en,
    input  logic [mips_pkg::XLEN-1:0]       mem_data_out,
    output logic                            wb_en,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_dest,
    output logic [mips_pkg::XLEN-1:0]       wb_data,
    output logic                            halted
);
    import mips_pkg::*;

    mem_wb_t mem_wb;
    logic    halt_wb;
    logic    halted_q;

    // the data port answers in the same cycle, so no wait state is needed
    assign mem_addr     = ex_mem.alu_result;
    assign mem_data_in  = ex_mem.store_data;
    assign mem_write_en = ex_mem.valid && ex_mem.ctrl.mem_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb   <= '0;
            halted_q <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.halt      <= ex_mem.ctrl.halt;
            mem_wb.result    <= ex_mem.ctrl.mem_read ? mem_data_out : ex_mem.alu_result;
            mem_wb.dest      <= ex_mem.dest;
            if (halt_wb) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign halt_wb = mem_wb.valid && mem_wb.halt;
    assign wb_en   = mem_wb.valid && mem_wb.reg_write;
    assign wb_dest = mem_wb.dest;
    assign wb_data = mem_wb.result;

    // high from the cycle the halt sits in writeback
    assign halted = halted_q || halt_wb;

    a_no_store_after_halt: assert property (
        @(posedge clk) disable iff (!arst_n) halted |-> !mem_write_en
    );

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic [mips_pkg::XLEN-1:0] inst_addr,
    input  logic [mips_pkg::XLEN-1:0] inst,
    output logic [mips_pkg::XLEN-1:0] mem_addr,
    output logic [mips_pkg::XLEN-1:0] mem_data_in,
    input  logic [mips_pkg::XLEN-1:0] mem_data_out,
    output logic                      mem_write_en,
    output logic                      halted
);
    import mips_pkg::*;

    inst_u                 if_inst;
    logic [XLEN-1:0]       if_pc_plus4;
    logic                  if_valid;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    logic                  stall;
    logic                  halt_seen;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic [XLEN-1:0]       wb_data;

    fetch_stage u_fetch_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .halt_seen   (halt_seen),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst        (inst),
        .inst_addr   (inst_addr),
        .if_inst     (if_inst),
        .if_pc_plus4 (if_pc_plus4),
        .if_valid    (if_valid)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .if_inst     (if_inst),
        .if_pc_plus4 (if_pc_plus4),
        .if_valid    (if_valid),
        .wb_en       (wb_en),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .ex_mem      (ex_mem),
        .id_ex       (id_ex),
        .stall       (stall),
        .halt_seen   (halt_seen)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_writeback u_memory_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_mem       (ex_mem),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .mem_data_out (mem_data_out),
        .wb_en        (wb_en),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // primary opcodes in bits 31:26 of every instruction
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } op_e;

    // function field of the SPECIAL opcode
    typedef enum logic [5:0] {
        FN_SYSCALL = 6'h0c,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // the same word seen as R, I or J format
    typedef union packed {
        struct packed {
            op_e                   op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            funct_e                funct;
        } r;
        struct packed {
            op_e                   op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm;
        } i;
        struct packed {
            op_e         op;
            logic [25:0] target;
        } j;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc_plus4;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [XLEN-1:0]       imm_ext;
        logic [XLEN-1:0]       jump_target;
        logic [REG_ADDR_W-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  halt;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] dest;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [mips_pkg::XLEN-1:0]       rs_data,
    output logic [mips_pkg::XLEN-1:0]       rt_data,
    input  logic                            wb_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_dest,
    input  logic [mips_pkg::XLEN-1:0]       wb_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (wb_en && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // write-through lets decode see a result that retires in this cycle
    always_comb begin
        if (rs_addr == '0) begin
            rs_data = '0;
        end else if (wb_en && wb_dest == rs_addr) begin
            rs_data = wb_data;
        end else begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr == '0) begin
            rt_data = '0;
        end else if (wb_en && wb_dest == rt_addr) begin
            rt_data = wb_data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

    a_wb_dest_known: assert property (
        @(posedge clk) disable iff (!arst_n) wb_en |-> !$isunknown(wb_dest)
    );

endmodule

`default_nettype wire

// ==== sim/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd, input int rs,
                                       input int rt);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

// assembly order, as in addiu rt, rs, imm or lw rt, imm(rs)
function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
                                       input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] j_word(input int target_word);
    return {OP_J, 26'(target_word)};
endfunction

task automatic load_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
        imem[i] = {6'h3f, 18'h0, 8'(i)};
        dmem[i] = {16'hda7a, 8'h00, 8'(i)};
    end
    for (int i = 0; i < 4; i++) begin
        dmem[i] = $urandom();
    end
    imem[0]  = i_word(OP_LW, 2, 0, 0);
    imem[1]  = i_word(OP_LW, 3, 0, 4);
    // the load result is needed by the very next instruction
    imem[2]  = r_word(FN_ADDU, 4, 2, 3);
    imem[3]  = i_word(OP_ADDIU, 10, 0, 'h100);
    imem[4]  = i_word(OP_SW, 4, 10, 0);
    imem[5]  = r_word(FN_SUBU, 5, 2, 3);
    imem[6]  = i_word(OP_SW, 5, 10, 4);
    imem[7]  = r_word(FN_AND, 6, 2, 3);
    imem[8]  = i_word(OP_SW, 6, 10, 8);
    imem[9]  = r_word(FN_OR, 7, 2, 3);
    imem[10] = i_word(OP_SW, 7, 10, 12);
    imem[11] = r_word(FN_SLT, 8, 2, 3);
    imem[12] = i_word(OP_SW, 8, 10, 16);
    imem[13] = i_word(OP_ADDIU, 9, 2, -5);
    imem[14] = r_word(FN_ADDU, 9, 9, 9);
    imem[15] = i_word(OP_SW, 9, 10, 20);
    imem[16] = i_word(OP_LW, 12, 0, 8);
    imem[17] = i_word(OP_SW, 12, 10, 24);
    // r10 holds 0x100 so this beq falls through
    imem[18] = i_word(OP_BEQ, 0, 10, 1);
    imem[19] = i_word(OP_SW, 10, 10, 28);
    imem[20] = i_word(OP_BEQ, 12, 12, 1);
    imem[21] = i_word(OP_SW, 2, 10, 32);
    imem[22] = j_word(24);
    imem[23] = i_word(OP_SW, 3, 10, 36);
    imem[24] = r_word(FN_SLT, 11, 3, 2);
    imem[25] = i_word(OP_SW, 11, 10, 40);
    imem[26] = r_word(FN_SYSCALL, 0, 0, 0);
    imem[27] = i_word(OP_SW, 2, 10, 44);
endtask

// sequential MIPS semantics, one instruction per step, with raw opcode values
task automatic run_reference_model();
    logic [31:0] regs [32];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    bit          done;
    regs        = '{default: '0};
    mem         = dmem;
    pc          = '0;
    done        = 1'b0;
    model_steps = 0;
    while (!done && model_steps < 1000) begin
        word = imem[pc[9:2]];
        a    = regs[word[25:21]];
        b    = regs[word[20:16]];
        imm  = {{16{word[15]}}, word[15:0]};
        pc   = pc + 32'd4;
        model_steps++;
        case (word[31:26])
            6'h00: begin
                case (word[5:0])
                    6'h21:   regs[word[15:11]] = a + b;
                    6'h23:   regs[word[15:11]] = a - b;
                    6'h24:   regs[word[15:11]] = a & b;
                    6'h25:   regs[word[15:11]] = a | b;
                    6'h2a:   regs[word[15:11]] = {31'd0, $signed(a) < $signed(b)};
                    6'h0c:   done = 1'b1;
                    default: ;
                endcase
            end
            6'h09: regs[word[20:16]] = a + imm;
            6'h23: regs[word[20:16]] = mem[8'((a + imm) >> 2)];
            6'h2b: begin
                mem[8'((a + imm) >> 2)] = b;
                exp_addr.push_back(a + imm);
                exp_data.push_back(b);
            end
            6'h04: begin
                if (a == b) begin
                    pc = pc + (imm << 2);
                end
            end
            6'h02:   pc = {pc[31:28], word[25:0], 2'b00};
            default: ;
        endcase
        regs[0] = '0;
    end
endtask

`endif

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int SEED         = 99523;

    logic            clk = 1'b0;
    logic            arst_n;
    logic [XLEN-1:0] inst_addr;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_data_in;
    logic [XLEN-1:0] mem_data_out;
    logic            mem_write_en;
    logic            halted;

    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              model_steps = 0;
    int              store_count = 0;
    logic            model_ready = 1'b0;
    logic            arst_n_prev = 1'b0;
    logic            halted_prev = 1'b0;

    `include "tb_program.svh"

    mips_core u_mips_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    // both memories answer in the same cycle
    assign inst         = imem[inst_addr[9:2]];
    assign mem_data_out = dmem[mem_addr[9:2]];

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        void'($urandom(SEED));
        load_memories();
        run_reference_model();
        model_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) arst_n = 1'b1;
        wait (halted);
        // a few more cycles show that halted holds and no store follows
        repeat (8) @(posedge clk);
        if (store_count == exp_addr.size()) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error($sformatf("FAILED at time %0t: %0d stores seen, %0d expected",
                                    $time, store_count, exp_addr.size()));
        end
    end

    initial begin
        wait (model_ready);
        repeat (10 * model_steps + 200) @(posedge clk);
        stop_on_error("watchdog expired: the core never raised halted");
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!arst_n || !arst_n_prev) begin
            assert (inst_addr == RESET_PC && !mem_write_en && !halted)
                else stop_on_error($sformatf(
                    "FAILED at time %0t: reset state inst_addr %h mem_write_en %b halted %b",
                    $time, inst_addr, mem_write_en, halted));
        end
        if (arst_n && mem_write_en) begin
            assert (store_count < exp_addr.size())
                else stop_on_error($sformatf(
                    "FAILED at time %0t: extra store to %h, only %0d expected",
                    $time, mem_addr, exp_addr.size()));
            assert (mem_addr == exp_addr[store_count] && mem_data_in == exp_data[store_count])
                else stop_on_error($sformatf(
                    "FAILED at time %0t: store %0d wrote %h to %h, expected %h to %h",
                    $time, store_count, mem_data_in, mem_addr,
                    exp_data[store_count], exp_addr[store_count]));
            dmem[mem_addr[9:2]] = mem_data_in;
            store_count++;
        end
        if (halted_prev) begin
            assert (halted)
                else stop_on_error($sformatf("FAILED at time %0t: halted fell", $time));
        end
        if (arst_n && halted && !halted_prev) begin
            assert (store_count == exp_addr.size())
                else stop_on_error($sformatf(
                    "FAILED at time %0t: halted after %0d stores, expected %0d",
                    $time, store_count, exp_addr.size()));
        end
        if (arst_n) begin
            assert (!(halted && mem_write_en))
                else stop_on_error($sformatf(
                    "FAILED at time %0t: store to %h while halted", $time, mem_addr));
        end
        arst_n_prev = arst_n;
        halted_prev = arst_n && halted;
    end

endmodule

`default_nettype wire
